// ==== design/wb_pkg.sv ====
////////////////////
// Writeback package
// Slot counts, offsets, widths and the category encoding
////////////////////
`default_nettype none

package wb_pkg;

    // Slots per category
    localparam int NUM_ALU  = 8;
    localparam int NUM_LS   = 4;
    localparam int NUM_MULT = 4;
    localparam int NUM_BEQ  = 4;

    // Exclusive upper slot index of each category
    // Slot order is ALU, LS, MULT, BEQ
    localparam int ALU_OFFSET  = NUM_ALU;
    localparam int LS_OFFSET   = ALU_OFFSET + NUM_LS;
    localparam int MULT_OFFSET = LS_OFFSET + NUM_MULT;
    localparam int BEQ_OFFSET  = MULT_OFFSET + NUM_BEQ;

    localparam int FU_SIZE     = BEQ_OFFSET;
    localparam int FU_IDX_BITS = $clog2(FU_SIZE);

    // Rotation counter spans the widest category
    localparam int CNT_BITS = $clog2(NUM_ALU);

    // Result payload
    localparam int XLEN     = 32;
    localparam int TAG_BITS = 6;

    // Numeric order is priority order, lowest first
    typedef enum logic [1:0] {
        CAT_ALU  = 2'd0,
        CAT_LS   = 2'd1,
        CAT_MULT = 2'd2,
        CAT_BEQ  = 2'd3
    } fu_category_t;

endpackage

`default_nettype wire

// ==== design/rotating_priority_tree.sv ====
////////////////////
// Rotating-priority grant tree
// Recursive halves steered by one counter bit per level
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rotating_priority_tree #(
    parameter int WIDTH = 8
) (
    input  wire  [WIDTH-1:0]         req,
    input  wire                      en,
    input  wire  [$clog2(WIDTH)-1:0] cnt,
    output logic [WIDTH-1:0]         gnt,
    output logic                     req_any
);

    generate
        if (WIDTH == 2) begin : g_cell
            // cnt high prefers the upper request, low prefers the lower one
            assign gnt[1] = en && req[1] && (cnt[0] || !req[0]);
            assign gnt[0] = en && req[0] && (!cnt[0] || !req[1]);
            assign req_any = req[1] || req[0];
        end else begin : g_split
            logic [1:0] half_any;
            logic [1:0] half_en;

            rotating_priority_tree #(
                .WIDTH(WIDTH / 2)
            ) u_upper (
                .req     (req[WIDTH-1:WIDTH/2]),
                .en      (half_en[1]),
                .cnt     (cnt[$clog2(WIDTH)-2:0]),
                .gnt     (gnt[WIDTH-1:WIDTH/2]),
                .req_any (half_any[1])
            );

            rotating_priority_tree #(
                .WIDTH(WIDTH / 2)
            ) u_lower (
                .req     (req[WIDTH/2-1:0]),
                .en      (half_en[0]),
                .cnt     (cnt[$clog2(WIDTH)-2:0]),
                .gnt     (gnt[WIDTH/2-1:0]),
                .req_any (half_any[0])
            );

            // Top bit of cnt steers between the two halves
            rotating_priority_tree #(
                .WIDTH(2)
            ) u_steer (
                .req     (half_any),
                .en      (en),
                .cnt     (cnt[$clog2(WIDTH)-1]),
                .gnt     (half_en),
                .req_any (req_any)
            );
        end
    endgenerate

    // Whole subtree grants at most one requester
    always_comb begin
        assert final ($onehot0(gnt) && ((gnt & ~req) == '0))
            else $error("rotating_priority_tree: bad grant %b for request %b", gnt, req);
    end

endmodule

`default_nettype wire

// ==== design/fu_result_buffer.sv ====
////////////////////
// Result holding register
// One entry between a functional unit and the bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fu_result_buffer (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             done,
    input  wire  [wb_pkg::TAG_BITS-1:0]     tag,
    input  wire  [wb_pkg::XLEN-1:0]         value,
    input  wire                             grant,
    output logic                            ready,
    output logic                            valid,
    output logic [wb_pkg::TAG_BITS-1:0]     held_tag,
    output logic [wb_pkg::XLEN-1:0]         held_value
);

    // Free now, or free at the end of this cycle
    assign ready = !valid || grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (done) begin
            // New result, possibly replacing one leaving this cycle
            valid <= 1'b1;
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (done) begin
            held_tag   <= tag;
            held_value <= value;
        end
    end

    // Unit must respect the ready level
    a_done_when_ready: assert property (
        @(posedge clock) disable iff (reset) done |-> ready
    ) else $error("fu_result_buffer: done while not ready");

    // Selector only grants occupied slots
    a_grant_has_valid: assert property (
        @(posedge clock) disable iff (reset) grant |-> valid
    ) else $error("fu_result_buffer: grant to empty slot");

    // Held result is not overwritten before it is broadcast
    a_hold_until_grant: assert property (
        @(posedge clock) disable iff (reset)
        (valid && !grant) |=> (valid && $stable(held_tag) && $stable(held_value))
    ) else $error("fu_result_buffer: pending result changed");

endmodule

`default_nettype wire

// ==== design/fu_selector.sv ====
////////////////////
// Result selector
// Picks one finished slot per cycle for the data bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fu_selector (
    input  wire                                                    clock,
    input  wire                                                    reset,
    input  wire  [wb_pkg::FU_SIZE-1:0]                             slot_valid,
    input  wire  [wb_pkg::FU_SIZE-1:0][wb_pkg::TAG_BITS-1:0]       slot_tag,
    input  wire  [wb_pkg::FU_SIZE-1:0][wb_pkg::XLEN-1:0]           slot_value,
    output logic [wb_pkg::FU_SIZE-1:0]                             grant,
    output logic                                                   sel_valid,
    output logic [wb_pkg::FU_IDX_BITS-1:0]                         sel_index,
    output wb_pkg::fu_category_t                                   sel_category,
    output logic [wb_pkg::TAG_BITS-1:0]                            sel_tag,
    output logic [wb_pkg::XLEN-1:0]                                sel_value
);

    logic [3:0]                      cat_req;
    logic [3:0]                      cat_en;
    logic [wb_pkg::CNT_BITS-1:0]     cnt;

    // Free-running rotation counter
    always_ff @(posedge clock) begin
        if (reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + wb_pkg::CNT_BITS'(1);
        end
    end

    assign cat_req[0] = |slot_valid[wb_pkg::ALU_OFFSET-1:0];
    assign cat_req[1] = |slot_valid[wb_pkg::LS_OFFSET-1:wb_pkg::ALU_OFFSET];
    assign cat_req[2] = |slot_valid[wb_pkg::MULT_OFFSET-1:wb_pkg::LS_OFFSET];
    assign cat_req[3] = |slot_valid[wb_pkg::BEQ_OFFSET-1:wb_pkg::MULT_OFFSET];

    // Fixed priority: branch, then multiply, then load/store, then ALU
    always_comb begin
        cat_en = '0;
        if (cat_req[3]) begin
            sel_category = wb_pkg::CAT_BEQ;
        end else if (cat_req[2]) begin
            sel_category = wb_pkg::CAT_MULT;
        end else if (cat_req[1]) begin
            sel_category = wb_pkg::CAT_LS;
        end else begin
            sel_category = wb_pkg::CAT_ALU;
        end
        cat_en[sel_category] = cat_req[sel_category];
    end

    rotating_priority_tree #(.WIDTH(wb_pkg::NUM_ALU)) u_alu_tree (
        .req     (slot_valid[wb_pkg::ALU_OFFSET-1:0]),
        .en      (cat_en[0]),
        .cnt     (cnt),
        .gnt     (grant[wb_pkg::ALU_OFFSET-1:0]),
        .req_any ()
    );

    rotating_priority_tree #(.WIDTH(wb_pkg::NUM_LS)) u_ls_tree (
        .req     (slot_valid[wb_pkg::LS_OFFSET-1:wb_pkg::ALU_OFFSET]),
        .en      (cat_en[1]),
        .cnt     (cnt[1:0]),
        .gnt     (grant[wb_pkg::LS_OFFSET-1:wb_pkg::ALU_OFFSET]),
        .req_any ()
    );

    rotating_priority_tree #(.WIDTH(wb_pkg::NUM_MULT)) u_mult_tree (
        .req     (slot_valid[wb_pkg::MULT_OFFSET-1:wb_pkg::LS_OFFSET]),
        .en      (cat_en[2]),
        .cnt     (cnt[1:0]),
        .gnt     (grant[wb_pkg::MULT_OFFSET-1:wb_pkg::LS_OFFSET]),
        .req_any ()
    );

    rotating_priority_tree #(.WIDTH(wb_pkg::NUM_BEQ)) u_beq_tree (
        .req     (slot_valid[wb_pkg::BEQ_OFFSET-1:wb_pkg::MULT_OFFSET]),
        .en      (cat_en[3]),
        .cnt     (cnt[1:0]),
        .gnt     (grant[wb_pkg::BEQ_OFFSET-1:wb_pkg::MULT_OFFSET]),
        .req_any ()
    );

    // One-hot grant to slot index
    always_comb begin
        sel_index = '0;
        for (int i = 0; i < wb_pkg::FU_SIZE; i++) begin
            if (grant[i]) begin
                sel_index = sel_index | wb_pkg::FU_IDX_BITS'(i);
            end
        end
    end

    assign sel_valid = |grant;
    assign sel_tag   = slot_tag[sel_index];
    assign sel_value = slot_value[sel_index];

    a_grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant));
    // Some slot is always served when any is pending
    a_no_idle: assert property (@(posedge clock) disable iff (reset) sel_valid == |slot_valid);

endmodule

`default_nettype wire

// ==== design/complete_stage.sv ====
////////////////////
// Completion stage top
// Twenty result slots feeding one common data bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

module complete_stage (
    input  wire                                                clock,
    input  wire                                                reset,
    input  wire  [wb_pkg::FU_SIZE-1:0]                         fu_done,
    input  wire  [wb_pkg::FU_SIZE-1:0][wb_pkg::TAG_BITS-1:0]   fu_tag,
    input  wire  [wb_pkg::FU_SIZE-1:0][wb_pkg::XLEN-1:0]       fu_value,
    output logic [wb_pkg::FU_SIZE-1:0]                         fu_ready,
    output logic                                               cdb_valid,
    output logic [wb_pkg::TAG_BITS-1:0]                        cdb_tag,
    output logic [wb_pkg::XLEN-1:0]                            cdb_value,
    output logic [wb_pkg::FU_IDX_BITS-1:0]                     cdb_fu,
    output wb_pkg::fu_category_t                               cdb_category
);

    logic [wb_pkg::FU_SIZE-1:0]                          slot_valid;
    logic [wb_pkg::FU_SIZE-1:0][wb_pkg::TAG_BITS-1:0]    slot_tag;
    logic [wb_pkg::FU_SIZE-1:0][wb_pkg::XLEN-1:0]        slot_value;
    logic [wb_pkg::FU_SIZE-1:0]                          grant;

    generate
        for (genvar i = 0; i < wb_pkg::FU_SIZE; i++) begin : g_slot
            fu_result_buffer u_buffer (
                .clock      (clock),
                .reset      (reset),
                .done       (fu_done[i]),
                .tag        (fu_tag[i]),
                .value      (fu_value[i]),
                .grant      (grant[i]),
                .ready      (fu_ready[i]),
                .valid      (slot_valid[i]),
                .held_tag   (slot_tag[i]),
                .held_value (slot_value[i])
            );
        end
    endgenerate

    // Selector output goes straight onto the bus
    fu_selector u_selector (
        .clock        (clock),
        .reset        (reset),
        .slot_valid   (slot_valid),
        .slot_tag     (slot_tag),
        .slot_value   (slot_value),
        .grant        (grant),
        .sel_valid    (cdb_valid),
        .sel_index    (cdb_fu),
        .sel_category (cdb_category),
        .sel_tag      (cdb_tag),
        .sel_value    (cdb_value)
    );

endmodule

`default_nettype wire

// ==== sim/complete_stage_checks.svh ====
////////////////////
// Bus compare tasks
////////////////////
`ifndef COMPLETE_STAGE_CHECKS_SVH
`define COMPLETE_STAGE_CHECKS_SVH

task automatic check_category(input string name, input wb_pkg::fu_category_t expected,
                              input wb_pkg::fu_category_t actual);
    if (actual !== expected) begin
        $display("Error: test %s category expected %s actual %s",
                 name, expected.name(), actual.name());
        errors++;
    end
endtask

task automatic check_index(input string name, input logic [wb_pkg::FU_IDX_BITS-1:0] expected,
                           input logic [wb_pkg::FU_IDX_BITS-1:0] actual);
    if (actual !== expected) begin
        $display("Error: test %s slot expected %0d actual %0d", name, expected, actual);
        errors++;
    end
endtask

task automatic check_tag(input string name, input logic [wb_pkg::TAG_BITS-1:0] expected,
                         input logic [wb_pkg::TAG_BITS-1:0] actual);
    if (actual !== expected) begin
        $display("Error: test %s tag expected %h actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_value(input string name, input logic [wb_pkg::XLEN-1:0] expected,
                           input logic [wb_pkg::XLEN-1:0] actual);
    if (actual !== expected) begin
        $display("Error: test %s value expected %h actual %h", name, expected, actual);
        errors++;
    end
endtask

`endif

// ==== sim/complete_stage_tb.sv ====
////////////////////
// Completion stage testbench
// Vector-driven injections with a scoreboard on the data bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

module complete_stage_tb;

    localparam int BCAST_TIMEOUT = 50;

    logic                                              clock;
    logic                                              reset;
    logic [wb_pkg::FU_SIZE-1:0]                        fu_done;
    logic [wb_pkg::FU_SIZE-1:0][wb_pkg::TAG_BITS-1:0]  fu_tag;
    logic [wb_pkg::FU_SIZE-1:0][wb_pkg::XLEN-1:0]      fu_value;
    logic [wb_pkg::FU_SIZE-1:0]                        fu_ready;
    logic                                              cdb_valid;
    logic [wb_pkg::TAG_BITS-1:0]                       cdb_tag;
    logic [wb_pkg::XLEN-1:0]                           cdb_value;
    logic [wb_pkg::FU_IDX_BITS-1:0]                    cdb_fu;
    wb_pkg::fu_category_t                              cdb_category;

    int    errors;
    int    tests;
    int    passed;
    int    test_broadcasts;
    int    total_injected;
    int    total_broadcasts;
    string test_name;

    // Scoreboard model of the occupied slots
    logic [wb_pkg::FU_SIZE-1:0] occupied;
    logic [wb_pkg::TAG_BITS-1:0] model_tag [wb_pkg::FU_SIZE];
    logic [wb_pkg::XLEN-1:0]     model_value [wb_pkg::FU_SIZE];

    // Injections of the current record
    int                          inj_off [$];
    int                          inj_slot [$];
    logic [wb_pkg::TAG_BITS-1:0] inj_tag [$];
    logic [wb_pkg::XLEN-1:0]     inj_val [$];

    `include "complete_stage_checks.svh"

    complete_stage DUT (
        .clock        (clock),
        .reset        (reset),
        .fu_done      (fu_done),
        .fu_tag       (fu_tag),
        .fu_value     (fu_value),
        .fu_ready     (fu_ready),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .cdb_fu       (cdb_fu),
        .cdb_category (cdb_category)
    );

    always #50 clock = !clock;

    function automatic wb_pkg::fu_category_t category_of(input int slot);
        if (slot < wb_pkg::ALU_OFFSET) begin
            return wb_pkg::CAT_ALU;
        end else if (slot < wb_pkg::LS_OFFSET) begin
            return wb_pkg::CAT_LS;
        end else if (slot < wb_pkg::MULT_OFFSET) begin
            return wb_pkg::CAT_MULT;
        end
        return wb_pkg::CAT_BEQ;
    endfunction

    // Highest-priority category still holding a result
    function automatic wb_pkg::fu_category_t top_category();
        wb_pkg::fu_category_t best;
        best = wb_pkg::CAT_ALU;
        for (int s = 0; s < wb_pkg::FU_SIZE; s++) begin
            if (occupied[s] && category_of(s) > best) begin
                best = category_of(s);
            end
        end
        return best;
    endfunction

    function automatic logic [wb_pkg::FU_IDX_BITS-1:0] first_slot(input wb_pkg::fu_category_t cat);
        for (int s = 0; s < wb_pkg::FU_SIZE; s++) begin
            if (occupied[s] && category_of(s) == cat) begin
                return wb_pkg::FU_IDX_BITS'(s);
            end
        end
        return '0;
    endfunction

    // Called mid-cycle, where the bus and ready levels are settled
    task automatic observe_cycle();
        wb_pkg::fu_category_t           exp_cat;
        logic [wb_pkg::FU_IDX_BITS-1:0] exp_idx;
        logic                           exp_ready;
        logic                           pending;
        int                             slot;
        slot = int'(cdb_fu);
        for (int s = 0; s < wb_pkg::FU_SIZE; s++) begin
            exp_ready = !occupied[s] || (cdb_valid && slot == s);
            if (fu_ready[s] !== exp_ready) begin
                $display("Error: test %s fu_ready[%0d] expected %b actual %b",
                         test_name, s, exp_ready, fu_ready[s]);
                errors++;
            end
            if (fu_done[s] && !fu_ready[s]) begin
                $display("Error: test %s drove done into slot %0d while it was not ready",
                         test_name, s);
                errors++;
            end
        end
        if (occupied == '0) begin
            if (cdb_valid !== 1'b0) begin
                $display("Error: test %s broadcast with no result pending", test_name);
                errors++;
            end
        end else if (cdb_valid !== 1'b1) begin
            $display("Error: test %s no broadcast while results were pending", test_name);
            errors++;
        end else begin
            exp_cat = top_category();
            check_category(test_name, exp_cat, cdb_category);
            // Any pending slot of that category may win the rotation
            pending = 1'b0;
            if (slot < wb_pkg::FU_SIZE) begin
                pending = occupied[slot] && category_of(slot) == exp_cat;
            end
            if (!pending) begin
                exp_idx = first_slot(exp_cat);
                check_index(test_name, exp_idx, cdb_fu);
            end
            if (slot < wb_pkg::FU_SIZE && occupied[slot]) begin
                check_tag(test_name, model_tag[slot], cdb_tag);
                check_value(test_name, model_value[slot], cdb_value);
                occupied[slot] = 1'b0;
            end
            test_broadcasts++;
            total_broadcasts++;
        end
        // Done pulses of this cycle occupy their slots from the next one
        for (int s = 0; s < wb_pkg::FU_SIZE; s++) begin
            if (fu_done[s] === 1'b1) begin
                occupied[s]    = 1'b1;
                model_tag[s]   = fu_tag[s];
                model_value[s] = fu_value[s];
                total_injected++;
            end
        end
    endtask

    task automatic report_test(input int start_errors);
        tests++;
        if (errors == start_errors) begin
            passed++;
            $display("test %-12s %0d broadcasts, ok", test_name, test_broadcasts);
        end else begin
            $display("test %-12s %0d broadcasts, %0d errors", test_name, test_broadcasts,
                     errors - start_errors);
        end
    endtask

    task automatic run_test(input int gap, input int expected_count);
        int                         start_errors;
        int                         last_off;
        logic [wb_pkg::FU_SIZE-1:0] next_done;
        start_errors = errors;
        test_broadcasts = 0;
        last_off = 0;
        foreach (inj_off[k]) begin
            if (inj_off[k] > last_off) begin
                last_off = inj_off[k];
            end
        end
        for (int c = 0; c < gap; c++) begin
            @(posedge clock);
            fu_done <= '0;
            @(negedge clock);
            observe_cycle();
        end
        for (int c = 0; c <= last_off + BCAST_TIMEOUT; c++) begin
            @(posedge clock);
            next_done = '0;
            foreach (inj_off[k]) begin
                if (inj_off[k] == c) begin
                    next_done[inj_slot[k]] = 1'b1;
                    fu_tag[inj_slot[k]]   <= inj_tag[k];
                    fu_value[inj_slot[k]] <= inj_val[k];
                end
            end
            fu_done <= next_done;
            @(negedge clock);
            observe_cycle();
            if (c >= last_off && occupied == '0) begin
                break;
            end
        end
        if (occupied != '0) begin
            $display("Error: test %s timed out waiting for broadcast", test_name);
            errors++;
        end
        if (test_broadcasts != expected_count) begin
            $display("Error: test %s broadcast count expected %0d actual %0d",
                     test_name, expected_count, test_broadcasts);
            errors++;
        end
        report_test(start_errors);
    endtask

    initial begin
        int                          fd;
        int                          start_errors;
        int                          gap;
        int                          expected_count;
        int                          off;
        int                          slot;
        int                          rnd;
        string                       line;
        logic [8*20-1:0]             name_text;
        logic [wb_pkg::TAG_BITS-1:0] tag;
        logic [wb_pkg::XLEN-1:0]     val;
        clock = 1'b0;
        reset = 1'b1;
        fu_done = '0;
        fu_tag = '0;
        fu_value = '0;
        occupied = '0;
        errors = 0;
        tests = 0;
        passed = 0;
        test_broadcasts = 0;
        total_injected = 0;
        total_broadcasts = 0;
        gap = 0;
        expected_count = 0;
        void'($urandom(70));
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        test_name = "reset";
        start_errors = errors;
        if (cdb_valid !== 1'b0) begin
            $display("Error: test reset cdb_valid expected 0 actual %b", cdb_valid);
            errors++;
        end
        if (fu_ready !== '1) begin
            $display("Error: test reset fu_ready expected %h actual %h", {wb_pkg::FU_SIZE{1'b1}},
                     fu_ready);
            errors++;
        end
        report_test(start_errors);
        fd = $fopen("sim/complete_stage_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: the test vector file could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) begin
                    continue;
                end
                if (line.getc(0) == "t") begin
                    void'($sscanf(line, "test %s %d %d", name_text, gap, expected_count));
                    test_name = string'(name_text);
                    inj_off.delete();
                    inj_slot.delete();
                    inj_tag.delete();
                    inj_val.delete();
                end else if (line.getc(0) == "i") begin
                    void'($sscanf(line, "inj %d %d %h %d %h", off, slot, tag, rnd, val));
                    if (rnd != 0) begin
                        val = $urandom;
                    end
                    inj_off.push_back(off);
                    inj_slot.push_back(slot);
                    inj_tag.push_back(tag);
                    inj_val.push_back(val);
                end else if (line.getc(0) == "e") begin
                    run_test(gap, expected_count);
                end
            end
            $fclose(fd);
        end
        if (total_injected != total_broadcasts) begin
            $display("Error: results lost or duplicated, %0d injected and %0d broadcast",
                     total_injected, total_broadcasts);
            errors++;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests, passed,
                 tests - passed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wb_select.f ====
+incdir+sim
design/wb_pkg.sv
design/rotating_priority_tree.sv
design/fu_result_buffer.sv
design/fu_selector.sv
design/complete_stage.sv
sim/complete_stage_tb.sv

// ==== Makefile ====
# Verilator flow for the completion stage

TOOL      = verilator
FLAGS     = --timing --assert
SIM_FLAGS = --binary -j 0
TOP       = complete_stage_tb
RTL_TOP   = complete_stage
FILELIST  = wb_select.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/complete_stage_testdata.txt ====
# test <name> <idle cycles before first injection> <expected broadcasts>, closed by end
# inj <cycle offset> <slot> <tag hex> <random value 1/0> <value hex>
test lone_alu 2 1
inj 0 5 0a 0 00001234
end
test lone_ls 2 1
inj 0 9 11 1 00000000
end
test lone_mult 2 1
inj 0 14 22 0 cafe0014
end
test lone_beq 2 1
inj 0 19 3f 0 beef0019
end
test mixed_prio 2 6
inj 0 2 01 1 00000000
inj 0 10 02 0 a000000a
inj 0 13 03 1 00000000
inj 0 17 04 0 b0000011
inj 0 18 05 0 b0000012
inj 3 19 06 0 b0000013
end
test alu_burst 2 8
inj 0 0 10 0 10000000
inj 0 1 11 1 00000000
inj 0 2 12 0 10000002
inj 0 3 13 1 00000000
inj 0 4 14 0 10000004
inj 0 5 15 1 00000000
inj 0 6 16 0 10000006
inj 0 7 17 1 00000000
end
test beq_burst 2 4
inj 0 16 20 0 20000010
inj 0 17 21 1 00000000
inj 0 18 22 0 20000012
inj 0 19 23 1 00000000
end
test refill_alu 2 3
inj 0 3 30 0 30000003
inj 0 16 31 0 30000010
inj 2 3 32 0 3000aaaa
end
test refill_ls 2 4
inj 0 12 38 0 4000000c
inj 0 13 39 0 4000000d
inj 0 8 3a 0 40000008
inj 3 8 3b 1 00000000
end
